// ==== Bender.yml ====
package:
  name: mem_controller

sources:
  - include_dirs:
      - .
    files:
      - mem_req_pkg.sv
      - mem_line_pkg.sv
      - latency_timer.sv
      - offchip_ram.sv
      - line_cache.sv
      - refill_fsm.sv
      - mem_controller.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_controller.sv

// ==== latency_timer.sv ====
/*
 off-chip latency timer
 loads the fixed access latency on start and pulses done at zero
 */
`timescale 1ns/100ps
`include "mem_consts.svh"

module latency_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic done
);

    localparam int CNT_W = $clog2(`OFFCHIP_LATENCY + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`OFFCHIP_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // high for the last busy cycle only
    assign done = busy && (cnt == '0);

endmodule

// ==== line_cache.sv ====
/*
 direct-mapped line cache
 tag compare and word read for the lookup address, byte-merged stores on
 a hit, whole line fill from the refill FSM and a victim view of the
 line that a miss would replace
 */
`timescale 1ns/100ps
`include "mem_consts.svh"

module line_cache
    import mem_req_pkg::*;
    import mem_line_pkg::*;
#(
    parameter bit TRACK_DIRTY = 1'b1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] lookup_addr,
    output logic        hit,
    output logic [31:0] rdata,
    input  data_req_t   store,
    input  logic        store_en,
    input  logic        fill_en,
    input  logic [31:0] fill_addr,
    input  line_t       fill_line,
    output logic        victim_dirty,
    output logic [31:0] victim_addr,
    output line_t       victim_line
);

    localparam int OFF_BITS = $clog2(`LINE_BYTES);
    localparam int IDX_BITS = $clog2(`CACHE_LINES);
    localparam int TAG_BITS = 32 - OFF_BITS - IDX_BITS;

    line_t                lines [`CACHE_LINES];
    logic [TAG_BITS-1:0]  tags  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid;
    logic [`CACHE_LINES-1:0] dirty;

    logic [IDX_BITS-1:0]   lk_idx;
    logic [TAG_BITS-1:0]   lk_tag;
    logic [OFF_BITS-3:0]   lk_word;
    logic [31:0]           lk_data;
    access_size_e          rd_size;

    logic [IDX_BITS-1:0]   st_idx;
    logic [TAG_BITS-1:0]   st_tag;
    logic [OFF_BITS-3:0]   st_word;
    logic                  st_hit;
    logic [3:0]            st_be;
    logic [31:0]           st_data;

    logic [IDX_BITS-1:0]   f_idx;
    logic [TAG_BITS-1:0]   f_tag;

    assign lk_idx  = lookup_addr[OFF_BITS+IDX_BITS-1:OFF_BITS];
    assign lk_tag  = lookup_addr[31:OFF_BITS+IDX_BITS];
    assign lk_word = lookup_addr[OFF_BITS-1:2];
    assign hit     = valid[lk_idx] && (tags[lk_idx] == lk_tag);

    // the store may address a different line than the lookup
    assign st_idx  = store.addr[OFF_BITS+IDX_BITS-1:OFF_BITS];
    assign st_tag  = store.addr[31:OFF_BITS+IDX_BITS];
    assign st_word = store.addr[OFF_BITS-1:2];
    assign st_hit  = valid[st_idx] && (tags[st_idx] == st_tag);

    assign f_idx = fill_addr[OFF_BITS+IDX_BITS-1:OFF_BITS];
    assign f_tag = fill_addr[31:OFF_BITS+IDX_BITS];

    // instruction fetches are always whole words
    always_comb begin
        if (TRACK_DIRTY) begin
            rd_size = store.size;
        end else begin
            rd_size = size_word;
        end
    end

    // word select, then lanes zero-extended
    always_comb begin
        lk_data = lines[lk_idx][lk_word*32 +: 32];
        case (rd_size)
            size_byte: rdata = {24'd0, lk_data[lookup_addr[1:0]*8 +: 8]};
            size_half: rdata = {16'd0, lk_data[lookup_addr[1]*16 +: 16]};
            default:   rdata = lk_data;
        endcase
    end

    // byte enables and replicated store data
    always_comb begin
        case (store.size)
            size_byte: begin
                st_be   = 4'b0001 << store.addr[1:0];
                st_data = {4{store.wdata[7:0]}};
            end
            size_half: begin
                st_be   = 4'b0011 << {store.addr[1], 1'b0};
                st_data = {2{store.wdata[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = store.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[f_idx] <= fill_line;
            tags[f_idx]  <= f_tag;
        end else if (store_en && st_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (st_be[b]) begin
                    lines[st_idx][st_word*32 + b*8 +: 8] <= st_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_en) begin
            valid[f_idx] <= 1'b1;
            dirty[f_idx] <= 1'b0;
        end else if (TRACK_DIRTY && store_en && st_hit) begin
            dirty[st_idx] <= 1'b1;
        end
    end

    // line currently sitting at the lookup index
    assign victim_dirty = valid[lk_idx] && dirty[lk_idx];
    assign victim_addr  = {tags[lk_idx], lk_idx, {OFF_BITS{1'b0}}};
    assign victim_line  = lines[lk_idx];

    // the FSM holds stores off while it fills
    assert property (@(posedge clk) disable iff (!rst) !(fill_en && store_en));

endmodule

// ==== mem_consts.svh ====
/*
 memory controller constants
 line geometry, cache depth, off-chip size and off-chip access latency
 */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bytes per cache line
`define LINE_BYTES 16

// lines per direct-mapped cache
`define CACHE_LINES 8

// backing store depth in lines
`define OFFCHIP_LINES 64

// cycles from an off-chip strobe to its ready pulse
`define OFFCHIP_LATENCY 4

`endif

// ==== mem_controller.sv ====
/*
 memory controller top level
 instruction and data caches in front of a shared refill FSM and a
 line-wide off-chip RAM
 */
`timescale 1ns/100ps

module mem_controller
    import mem_req_pkg::*;
    import mem_line_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  inst_req_t   inst_req,
    output logic [31:0] inst_rdata,
    output logic        inst_ready,
    input  data_req_t   data_req,
    output logic [31:0] data_rdata,
    output logic        data_ready
);

    logic         inst_hit;
    logic         data_hit;
    logic         store_en;
    logic         inst_fill_en;
    logic         data_fill_en;
    logic [31:0]  fill_addr;
    line_t        fill_line;
    logic         victim_dirty;
    logic [31:0]  victim_addr;
    line_t        victim_line;
    offchip_req_t off_req;
    logic         off_ready;
    line_t        rd_line;

    // read only, follows data stores that hit its lines
    line_cache #(
        .TRACK_DIRTY (1'b0)
    ) i_cache_inst (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (inst_req.addr),
        .hit          (inst_hit),
        .rdata        (inst_rdata),
        .store        (data_req),
        .store_en     (store_en),
        .fill_en      (inst_fill_en),
        .fill_addr    (fill_addr),
        .fill_line    (fill_line),
        .victim_dirty (),
        .victim_addr  (),
        .victim_line  ()
    );

    line_cache #(
        .TRACK_DIRTY (1'b1)
    ) i_cache_data (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (data_req.addr),
        .hit          (data_hit),
        .rdata        (data_rdata),
        .store        (data_req),
        .store_en     (store_en),
        .fill_en      (data_fill_en),
        .fill_addr    (fill_addr),
        .fill_line    (fill_line),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line)
    );

    refill_fsm i_refill_fsm (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .inst_hit     (inst_hit),
        .data_hit     (data_hit),
        .inst_ready   (inst_ready),
        .data_ready   (data_ready),
        .store_en     (store_en),
        .inst_fill_en (inst_fill_en),
        .data_fill_en (data_fill_en),
        .fill_addr    (fill_addr),
        .fill_line    (fill_line),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .off_req      (off_req),
        .off_ready    (off_ready),
        .rd_line      (rd_line)
    );

    offchip_ram i_offchip_ram (
        .clk       (clk),
        .rst       (rst),
        .req       (off_req),
        .rd_line   (rd_line),
        .off_ready (off_ready)
    );

endmodule

// ==== mem_line_pkg.sv ====
/*
 line side types
 cache line, refill state and the off-chip request bundle
 */
package mem_line_pkg;

`include "mem_consts.svh"

    typedef logic [`LINE_BYTES*8-1:0] line_t;

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_read,
        st_fill
    } refill_state_e;

    // addr is always line aligned
    typedef struct packed {
        logic [31:0] addr;
        line_t       wdata;
        logic        rd;
        logic        wr;
    } offchip_req_t;

endpackage

// ==== mem_req_pkg.sv ====
/*
 processor request types
 access size encoding and the instruction and data channel requests
 */
package mem_req_pkg;

    // encoding follows the core's byte_size field
    typedef enum logic [1:0] {
        size_word = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2
    } access_size_e;

    // instruction fetch, read only
    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
    } inst_req_t;

    // data access, byte address plus store payload
    typedef struct packed {
        logic [31:0]  addr;
        logic [31:0]  wdata;
        access_size_e size;
        logic         rd;
        logic         wr;
    } data_req_t;

endpackage

// ==== offchip_ram.sv ====
/*
 off-chip backing RAM
 line-wide storage that latches a request on its strobe and completes
 the read or write when the latency timer expires
 */
`timescale 1ns/100ps
`include "mem_consts.svh"

module offchip_ram
    import mem_line_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  offchip_req_t req,
    output line_t        rd_line,
    output logic         off_ready
);

    localparam int OFF_BITS = $clog2(`LINE_BYTES);
    localparam int RAM_BITS = $clog2(`OFFCHIP_LINES);

    line_t               mem [`OFFCHIP_LINES];
    logic [RAM_BITS-1:0] idx_q;
    line_t               wdata_q;
    logic                wr_q;
    logic                strobe;
    logic                timer_busy;
    logic                done;

    assign strobe = req.rd || req.wr;

    latency_timer i_latency_timer (
        .clk   (clk),
        .rst   (rst),
        .start (strobe),
        .busy  (timer_busy),
        .done  (done)
    );

    always_ff @(posedge clk) begin
        if (strobe) begin
            // upper address bits wrap onto the store
            idx_q   <= req.addr[OFF_BITS+RAM_BITS-1:OFF_BITS];
            wdata_q <= req.wdata;
            wr_q    <= req.wr;
        end
        if (done && wr_q) begin
            mem[idx_q] <= wdata_q;
        end
    end

    assign rd_line   = mem[idx_q];
    assign off_ready = done;

    // one access at a time
    assert property (@(posedge clk) disable iff (!rst) strobe |-> !timer_busy);

endmodule

// ==== refill_fsm.sv ====
/*
 refill FSM
 ready pulses and store enable for both channels on a hit, and one
 shared miss sequencer that writes back a dirty data victim, reads the
 line from off-chip and fills the cache that missed
 */
`timescale 1ns/100ps
`include "mem_consts.svh"

module refill_fsm
    import mem_req_pkg::*;
    import mem_line_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  inst_req_t    inst_req,
    input  data_req_t    data_req,
    input  logic         inst_hit,
    input  logic         data_hit,
    output logic         inst_ready,
    output logic         data_ready,
    output logic         store_en,
    output logic         inst_fill_en,
    output logic         data_fill_en,
    output logic [31:0]  fill_addr,
    output line_t        fill_line,
    input  logic         victim_dirty,
    input  logic [31:0]  victim_addr,
    input  line_t        victim_line,
    output offchip_req_t off_req,
    input  logic         off_ready,
    input  line_t        rd_line
);

    localparam int OFF_BITS = $clog2(`LINE_BYTES);

    refill_state_e state;
    logic          serve_data;
    logic          data_act;
    logic          data_go;
    logic          inst_go;
    logic          data_miss;
    logic          inst_miss;
    logic [31:0]   data_base;
    logic [31:0]   inst_base;

    assign data_act = data_req.rd || data_req.wr;

    // a held request is not answered twice, and no store lands
    // while a line is being filled
    assign data_go = data_act && data_hit && !data_ready && (state != st_fill);
    assign inst_go = inst_req.rd && inst_hit && !inst_ready;

    assign data_miss = data_act && !data_hit;
    assign inst_miss = inst_req.rd && !inst_hit;

    assign store_en = data_go && data_req.wr;

    assign data_base = {data_req.addr[31:OFF_BITS], {OFF_BITS{1'b0}}};
    assign inst_base = {inst_req.addr[31:OFF_BITS], {OFF_BITS{1'b0}}};

    assign inst_fill_en = (state == st_fill) && !serve_data;
    assign data_fill_en = (state == st_fill) && serve_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= st_idle;
            serve_data <= 1'b0;
            inst_ready <= 1'b0;
            data_ready <= 1'b0;
            off_req.rd <= 1'b0;
            off_req.wr <= 1'b0;
        end else begin
            inst_ready <= inst_go;
            data_ready <= data_go;
            // off-chip strobes last one cycle
            off_req.rd <= 1'b0;
            off_req.wr <= 1'b0;
            case (state)
                st_idle: begin
                    // data misses go first
                    if (data_miss) begin
                        serve_data <= 1'b1;
                        fill_addr  <= data_base;
                        if (victim_dirty) begin
                            state         <= st_writeback;
                            off_req.wr    <= 1'b1;
                            off_req.addr  <= victim_addr;
                            off_req.wdata <= victim_line;
                        end else begin
                            state        <= st_read;
                            off_req.rd   <= 1'b1;
                            off_req.addr <= data_base;
                        end
                    end else if (inst_miss) begin
                        serve_data   <= 1'b0;
                        fill_addr    <= inst_base;
                        state        <= st_read;
                        off_req.rd   <= 1'b1;
                        off_req.addr <= inst_base;
                    end
                end
                st_writeback: begin
                    if (off_ready) begin
                        state        <= st_read;
                        off_req.rd   <= 1'b1;
                        off_req.addr <= fill_addr;
                    end
                end
                st_read: begin
                    if (off_ready) begin
                        fill_line <= rd_line;
                        state     <= st_fill;
                    end
                end
                st_fill: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst) !(off_req.rd && off_req.wr));

    // the line that answered is still held while ready is high
    assert property (@(posedge clk) disable iff (!rst)
        data_ready |-> data_hit);
    assert property (@(posedge clk) disable iff (!rst)
        inst_ready |-> inst_hit);

endmodule

// ==== tb_mem_controller.sv ====
/*
 memory controller testbench
 random word, half and byte traffic checked against a flat byte model,
 hit latency, write-back and refill through conflicting lines,
 instruction fetches after eviction and after in-place store updates,
 and instruction and data misses raised in the same cycle
 */
`timescale 1ns/100ps
`include "mem_consts.svh"

module tb_mem_controller
    import mem_req_pkg::*;
();

    localparam int MEM_BYTES  = `OFFCHIP_LINES * `LINE_BYTES;
    localparam int REGION     = `CACHE_LINES * `LINE_BYTES;
    localparam int WAIT_LIMIT = 100;

    // three regions that share cache indices but differ in tag
    localparam logic [31:0] BASE_A = 32'd0;
    localparam logic [31:0] BASE_B = REGION;
    localparam logic [31:0] BASE_C = 2 * REGION;

    typedef struct packed {
        logic        check;
        logic [31:0] value;
    } expect_t;

    logic        clk;
    logic        rst;
    inst_req_t   inst_req;
    data_req_t   data_req;
    logic [31:0] inst_rdata;
    logic [31:0] data_rdata;
    logic        inst_ready;
    logic        data_ready;

    logic [7:0]  ref_mem [MEM_BYTES];
    expect_t     data_expect [$];
    expect_t     inst_expect [$];

    mem_controller i_mem_controller (
        .clk        (clk),
        .rst        (rst),
        .inst_req   (inst_req),
        .inst_rdata (inst_rdata),
        .inst_ready (inst_ready),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .data_ready (data_ready)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // little endian, lanes picked by the low address bits
    function automatic logic [31:0] ref_read(input logic [31:0] addr,
                                             input access_size_e size);
        int a;
        a = addr;
        case (size)
            size_byte: ref_read = {24'd0, ref_mem[a]};
            size_half: ref_read = {16'd0, ref_mem[a+1], ref_mem[a]};
            default: begin
                a = a & ~3;
                ref_read = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
            end
        endcase
    endfunction

    task automatic ref_write(input logic [31:0] addr, input access_size_e size,
                             input logic [31:0] wdata);
        int a;
        a = addr;
        ref_mem[a] = wdata[7:0];
        if (size != size_byte) begin
            ref_mem[a+1] = wdata[15:8];
        end
        if (size == size_word) begin
            ref_mem[a+2] = wdata[23:16];
            ref_mem[a+3] = wdata[31:24];
        end
    endtask

    function automatic access_size_e random_size();
        case ($urandom_range(2, 0))
            0:       random_size = size_word;
            1:       random_size = size_byte;
            default: random_size = size_half;
        endcase
    endfunction

    function automatic logic [31:0] align_addr(input logic [31:0] addr,
                                               input access_size_e size);
        case (size)
            size_word: align_addr = addr & ~32'd3;
            size_half: align_addr = addr & ~32'd1;
            default:   align_addr = addr;
        endcase
    endfunction

    // one data access, cycles counts falling edges up to ready
    task automatic data_access(input logic [31:0] addr, input access_size_e size,
                               input logic wr, input logic [31:0] wdata,
                               output int cycles);
        expect_t e;
        int      waited;
        @(negedge clk);
        e.check = !wr;
        e.value = wr ? 32'd0 : ref_read(addr, size);
        if (wr) begin
            ref_write(addr, size, wdata);
        end
        data_expect.push_back(e);
        data_req.addr  = addr;
        data_req.wdata = wdata;
        data_req.size  = size;
        data_req.rd    = !wr;
        data_req.wr    = wr;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("data channel never raised data_ready");
            end
        end while (!data_ready);
        data_req.rd = 1'b0;
        data_req.wr = 1'b0;
        cycles = waited;
    endtask

    task automatic fetch_inst(input logic [31:0] addr, output int cycles);
        expect_t e;
        int      waited;
        @(negedge clk);
        e.check = 1'b1;
        e.value = ref_read(addr, size_word);
        inst_expect.push_back(e);
        inst_req.addr = addr;
        inst_req.rd   = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("instruction channel never raised inst_ready");
            end
        end while (!inst_ready);
        inst_req.rd = 1'b0;
        cycles = waited;
    endtask

    // read data is checked in the ready cycle
    always @(negedge clk) begin
        expect_t e;
        if (rst && data_ready) begin
            if (data_expect.size() == 0) begin
                abort_run("data_ready pulsed with no data request outstanding");
            end
            e = data_expect.pop_front();
            if (e.check) begin
                check_value("data_rdata", data_rdata, e.value);
            end
        end
        if (rst && inst_ready) begin
            if (inst_expect.size() == 0) begin
                abort_run("inst_ready pulsed with no fetch outstanding");
            end
            e = inst_expect.pop_front();
            check_value("inst_rdata", inst_rdata, e.value);
        end
    end

    initial begin
        int           seed_val;
        int           cycles;
        int           icyc;
        logic [31:0]  addr;
        logic [31:0]  iaddr;
        access_size_e size;

        seed_val    = $urandom(92944);
        clk         = 1'b0;
        rst         = 1'b0;
        inst_req    = '0;
        data_req    = '0;
        data_req.size = size_word;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // whole words first, off-chip content is undefined
        for (int w = 0; w < REGION / 4; w++) begin
            data_access(BASE_A + 4 * w, size_word, 1'b1, $urandom, cycles);
        end
        // mixed sizes on region A
        for (int i = 0; i < 48; i++) begin
            size = random_size();
            addr = align_addr(BASE_A + $urandom_range(REGION - 1, 0), size);
            data_access(addr, size, $urandom_range(1, 0) == 1, $urandom, cycles);
        end
        for (int w = 0; w < REGION / 4; w++) begin
            data_access(BASE_A + 4 * w, size_word, 1'b0, 32'd0, cycles);
        end

        // second read of a held line is a one cycle hit
        data_access(BASE_A + 32'h10, size_word, 1'b0, 32'd0, cycles);
        data_access(BASE_A + 32'h14, size_word, 1'b0, 32'd0, cycles);
        check_value("data_ready latency", cycles, 32'd1);
        data_access(BASE_A + 32'h1e, size_half, 1'b0, 32'd0, cycles);
        check_value("data_ready latency", cycles, 32'd1);

        // B evicts dirty A, C evicts dirty B, reads bring them back
        for (int w = 0; w < REGION / 4; w++) begin
            data_access(BASE_B + 4 * w, size_word, 1'b1, $urandom, cycles);
        end
        for (int w = 0; w < REGION / 4; w++) begin
            data_access(BASE_C + 4 * w, size_word, 1'b1, $urandom, cycles);
        end
        for (int w = 0; w < REGION / 4; w++) begin
            data_access(BASE_A + 4 * w, size_word, 1'b0, 32'd0, cycles);
        end
        for (int w = 0; w < REGION / 4; w++) begin
            data_access(BASE_B + 4 * w, size_word, 1'b0, 32'd0, cycles);
        end

        // A and C are now only current off-chip
        for (int w = 0; w < REGION / 4; w++) begin
            fetch_inst(BASE_A + 4 * w, icyc);
        end
        for (int w = 0; w < REGION / 4; w++) begin
            fetch_inst(BASE_C + 4 * w, icyc);
        end

        // stores into lines the instruction cache holds
        for (int i = 0; i < 8; i++) begin
            size = random_size();
            addr = align_addr(BASE_C + $urandom_range(REGION - 1, 0), size);
            data_access(addr, size, 1'b1, $urandom, cycles);
            fetch_inst(addr & ~32'd3, icyc);
        end

        // both channels miss in the same cycle, on different lines
        for (int k = 0; k < `CACHE_LINES; k++) begin
            iaddr = BASE_A + k * `LINE_BYTES + 4 * $urandom_range(3, 0);
            addr  = BASE_A + ((k + 1) % `CACHE_LINES) * `LINE_BYTES
                    + 4 * $urandom_range(3, 0);
            fork
                fetch_inst(iaddr, icyc);
                data_access(addr, size_word, 1'b0, 32'd0, cycles);
            join
        end

        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
mem_req_pkg.sv
mem_line_pkg.sv
latency_timer.sv
offchip_ram.sv
line_cache.sv
refill_fsm.sv
mem_controller.sv
tb_mem_controller.sv
